// File: rtl/dm9000a_pkg.sv
package dm9000a_pkg;

   typedef logic [7:0]  enet_reg_t;
   typedef logic [15:0] data_word_t;

   ////////////////////
   // Register indices.
   localparam enet_reg_t REG_NCR    = 8'h00;
   localparam enet_reg_t REG_NSR    = 8'h01;
   localparam enet_reg_t REG_RXCR   = 8'h05;
   localparam enet_reg_t REG_PAR_0  = 8'h10;
   localparam enet_reg_t REG_GPR    = 8'h1F;
   localparam enet_reg_t REG_MRCMDX = 8'hF0;
   localparam enet_reg_t REG_MRCMD  = 8'hF2;
   localparam enet_reg_t REG_ISR    = 8'hFE;
   localparam enet_reg_t REG_IMR    = 8'hFF;

   // Register bit masks.
   localparam logic [7:0] NCR_RST       = 8'h01;
   localparam logic [7:0] NSR_TX1_END   = 8'h04;
   localparam logic [7:0] NSR_TX2_END   = 8'h08;
   localparam logic [7:0] NSR_WAKE      = 8'h20;
   localparam logic [7:0] NSR_LINK      = 8'h40;
   localparam logic [7:0] RXCR_RXEN     = 8'h01;
   localparam logic [7:0] RXCR_PRMSC    = 8'h02;
   localparam logic [7:0] IMR_PRI       = 8'h01;
   localparam logic [7:0] IMR_LNKCHGI   = 8'h20;
   localparam logic [7:0] IMR_PAR       = 8'h80;
   localparam logic [7:0] IMR_RUN_FLAGS = IMR_PAR | IMR_LNKCHGI | IMR_PRI;
   localparam logic [7:0] ISR_PR        = 8'h01;
   localparam logic [7:0] ISR_LNKCHG    = 8'h20;
   localparam logic [7:0] ISR_ALL       = 8'h3F;

   // Error bits of the receive status byte; the multicast flag is not an error.
   localparam logic [7:0] RX_BAD_FLAGS  = 8'hBF;

   // Level of the CMD pin.
   localparam logic CMD_INDEX = 1'b0;
   localparam logic CMD_DATA  = 1'b1;

   ////////////////////
   // Command from the control FSM to the bus sequencer.
   typedef struct packed {
      logic       read;
      enet_reg_t  reg_idx;
      data_word_t data;
   } bus_cmd_t;

   // Chip strobe pins.
   typedef struct packed {
      logic cmd;
      logic wr_n;
      logic rd_n;
   } enet_ctrl_t;

   // Word read from MRCMDX or at the start of a packet.
   typedef struct packed {
      logic [7:0] status;
      logic [7:0] ready;
   } rx_status_t;

   typedef union packed {
      data_word_t raw;
      rx_status_t rx;
   } enet_word_u;

   typedef enum logic [4:0] {
      CS_SPIN, CS_RESET, CS_PHY, CS_INIT, CS_IMR, CS_IDLE,
      CS_IRQ_MASK, CS_IRQ_READ, CS_IRQ_CLEAR, CS_DISPATCH,
      CS_LINK_READ, CS_LINK_UPDATE, CS_RX_PREFETCH, CS_RX_CHECK
   } cmd_state_e;

   typedef enum logic [4:0] {
      BS_IDLE, BS_INDEX, BS_SPIN, BS_WRITE, BS_READ,
      BS_PF_SPIN0, BS_PF_SPIN1, BS_PF_READ, BS_CAPTURE,
      BS_RX_STAT, BS_RX_CHECK, BS_RX_REQ, BS_RX_WORD,
      BS_RX_CRC_SPIN, BS_RX_CRC, BS_RX_DONE
   } bus_state_e;

   // Byte register write, zero-extended onto the bus.
   function automatic bus_cmd_t reg_write(enet_reg_t idx, logic [7:0] value);
      return '{read: 1'b0, reg_idx: idx, data: {8'h00, value}};
   endfunction

   function automatic bus_cmd_t reg_read(enet_reg_t idx);
      return '{read: 1'b1, reg_idx: idx, data: 16'h0000};
   endfunction

endpackage

// File: rtl/dm9000a_init_rom.sv
`timescale 1ns/1ps

module dm9000a_init_rom #(
   parameter logic [47:0] MAC_ADDRESS    = 48'h010203040506,
   parameter logic        PROMISCUOUS_EN = 1'b1
) (
   input  logic [3:0]            step,
   output dm9000a_pkg::bus_cmd_t entry,
   output logic                  last
);
   import dm9000a_pkg::*;

   logic [2:0] mac_sel;

   // Steps 2 to 7 select MAC bytes 0 to 5.
   assign mac_sel = step[2:0] - 3'd2;

   always_comb begin
      last = 1'b0;
      case (step)
         4'd0: begin
            // Clear the TX done and wake flags.
            entry = reg_write(REG_NSR, NSR_WAKE | NSR_TX2_END | NSR_TX1_END);
         end
         4'd1: begin
            entry = reg_write(REG_ISR, ISR_ALL);
         end
         4'd2, 4'd3, 4'd4, 4'd5, 4'd6, 4'd7: begin
            entry = reg_write(REG_PAR_0 + enet_reg_t'(mac_sel), MAC_ADDRESS[8*mac_sel +: 8]);
         end
         default: begin
            // Receive enable closes the table.
            entry = reg_write(REG_RXCR, PROMISCUOUS_EN ? (RXCR_RXEN | RXCR_PRMSC) : RXCR_RXEN);
            last  = 1'b1;
         end
      endcase
   end

endmodule

// File: rtl/dm9000a_cmd_ctrl.sv
`timescale 1ns/1ps

module dm9000a_cmd_ctrl #(
   parameter logic [47:0] MAC_ADDRESS    = 48'h010203040506,
   parameter logic        PROMISCUOUS_EN = 1'b1,
   parameter int          RESET_SPIN     = 1000,
   parameter int          PHY_SPIN       = 1000
) (
   input  logic                    clk_enet,
   input  logic                    reset,
   input  logic                    enet_int,
   input  logic                    busy,
   input  dm9000a_pkg::enet_word_u rd_data,
   output logic                    issue,
   output dm9000a_pkg::bus_cmd_t   cmd,
   output logic                    link_status
);
   import dm9000a_pkg::*;

   localparam int SPIN_MAX = (RESET_SPIN > PHY_SPIN) ? RESET_SPIN : PHY_SPIN;
   localparam int SPIN_W   = $clog2(SPIN_MAX + 1);

   cmd_state_e        state;
   cmd_state_e        spin_next;
   logic [SPIN_W-1:0] spin_cnt;
   logic [3:0]        step;
   bus_cmd_t          rom_entry;
   logic              rom_last;
   logic [7:0]        irq_flags;
   logic              can_issue;

   dm9000a_init_rom #(
      .MAC_ADDRESS   (MAC_ADDRESS),
      .PROMISCUOUS_EN(PROMISCUOUS_EN)
   ) u_init_rom (
      .step (step),
      .entry(rom_entry),
      .last (rom_last)
   );

   // Busy only rises the cycle after issue, so skip that cycle too.
   assign can_issue = !busy && !issue;

   always_ff @(posedge clk_enet) begin
      if (reset) begin
         // Let the chip finish its power-on reset first.
         state       <= CS_SPIN;
         spin_cnt    <= SPIN_W'(PHY_SPIN);
         spin_next   <= CS_RESET;
         step        <= 4'd0;
         irq_flags   <= 8'h00;
         issue       <= 1'b0;
         link_status <= 1'b0;
      end else begin
         issue <= 1'b0;
         if (state == CS_SPIN) begin
            if (spin_cnt == '0) begin
               state <= spin_next;
            end else begin
               spin_cnt <= spin_cnt - 1'b1;
            end
         end else if (can_issue) begin
            case (state)
               ////////////////////
               // Initialization.
               CS_RESET: begin
                  issue     <= 1'b1;
                  cmd       <= reg_write(REG_NCR, NCR_RST);
                  spin_cnt  <= SPIN_W'(RESET_SPIN);
                  spin_next <= CS_PHY;
                  state     <= CS_SPIN;
               end
               CS_PHY: begin
                  // GPIO0 low powers up the internal PHY.
                  issue     <= 1'b1;
                  cmd       <= reg_write(REG_GPR, 8'h00);
                  spin_cnt  <= SPIN_W'(PHY_SPIN);
                  spin_next <= CS_INIT;
                  step      <= 4'd0;
                  state     <= CS_SPIN;
               end
               CS_INIT: begin
                  issue <= 1'b1;
                  cmd   <= rom_entry;
                  step  <= step + 4'd1;
                  if (rom_last) begin
                     state <= CS_IMR;
                  end
               end
               CS_IMR: begin
                  issue <= 1'b1;
                  cmd   <= reg_write(REG_IMR, IMR_RUN_FLAGS);
                  state <= CS_IDLE;
               end
               CS_IDLE: begin
                  if (enet_int) begin
                     state <= CS_IRQ_MASK;
                  end
               end
               ////////////////////
               // Interrupt handler.
               CS_IRQ_MASK: begin
                  // Keep pointer wrap on, all sources masked.
                  issue <= 1'b1;
                  cmd   <= reg_write(REG_IMR, IMR_PAR);
                  state <= CS_IRQ_READ;
               end
               CS_IRQ_READ: begin
                  issue <= 1'b1;
                  cmd   <= reg_read(REG_ISR);
                  state <= CS_IRQ_CLEAR;
               end
               CS_IRQ_CLEAR: begin
                  irq_flags <= rd_data.raw[7:0];
                  issue     <= 1'b1;
                  cmd       <= reg_write(REG_ISR, ISR_ALL);
                  state     <= CS_DISPATCH;
               end
               CS_DISPATCH: begin
                  if ((irq_flags & ISR_PR) != 8'h00) begin
                     irq_flags <= irq_flags & ~ISR_PR;
                     state     <= CS_RX_PREFETCH;
                  end else if ((irq_flags & ISR_LNKCHG) != 8'h00) begin
                     irq_flags <= irq_flags & ~ISR_LNKCHG;
                     state     <= CS_LINK_READ;
                  end else begin
                     state <= CS_IMR;
                  end
               end
               CS_LINK_READ: begin
                  issue <= 1'b1;
                  cmd   <= reg_read(REG_NSR);
                  state <= CS_LINK_UPDATE;
               end
               CS_LINK_UPDATE: begin
                  link_status <= (rd_data.raw[7:0] & NSR_LINK) != 8'h00;
                  state       <= CS_DISPATCH;
               end
               CS_RX_PREFETCH: begin
                  issue <= 1'b1;
                  cmd   <= reg_read(REG_MRCMDX);
                  state <= CS_RX_CHECK;
               end
               CS_RX_CHECK: begin
                  // Ready byte 1 means a frame waits in chip SRAM.
                  if (rd_data.rx.ready == 8'd1) begin
                     issue <= 1'b1;
                     cmd   <= reg_read(REG_MRCMD);
                     state <= CS_RX_PREFETCH;
                  end else begin
                     state <= CS_DISPATCH;
                  end
               end
               default: begin
                  state <= CS_IDLE;
               end
            endcase
         end
      end
   end

   a_issue_idle: assert property (@(posedge clk_enet) disable iff (reset) issue |-> !busy)
      else $error("Command issued while the bus sequencer is busy.");

endmodule

// File: rtl/dm9000a_bus_seq.sv
`timescale 1ns/1ps

module dm9000a_bus_seq (
   input  logic                    clk_enet,
   input  logic                    reset,
   input  logic                    issue,
   input  dm9000a_pkg::bus_cmd_t   cmd,
   input  dm9000a_pkg::data_word_t enet_data_in,
   input  logic                    fifo_full,
   input  logic                    halt,
   output logic                    busy,
   output dm9000a_pkg::enet_word_u rd_data,
   output dm9000a_pkg::enet_ctrl_t enet_ctrl,
   output dm9000a_pkg::data_word_t enet_data_out,
   output logic                    fifo_wr,
   output dm9000a_pkg::data_word_t fifo_wdata
);
   import dm9000a_pkg::*;

   localparam enet_ctrl_t CTRL_IDLE  = '{cmd: CMD_DATA,  wr_n: 1'b1, rd_n: 1'b1};
   localparam enet_ctrl_t CTRL_INDEX = '{cmd: CMD_INDEX, wr_n: 1'b0, rd_n: 1'b1};
   localparam enet_ctrl_t CTRL_WRITE = '{cmd: CMD_DATA,  wr_n: 1'b0, rd_n: 1'b1};
   localparam enet_ctrl_t CTRL_READ  = '{cmd: CMD_DATA,  wr_n: 1'b1, rd_n: 1'b0};

   bus_state_e state;
   bus_cmd_t   cur;
   enet_word_u in_word;
   data_word_t rx_rem;
   logic       rx_bad;
   logic       rx_have_len;
   logic       rx_stall;

   assign in_word.raw = enet_data_in;
   assign busy        = state != BS_IDLE;

   // Bad frames are drained regardless of back-pressure.
   assign rx_stall = (fifo_full || halt) && !rx_bad;

   // Each receive word goes to the FIFO in its read strobe cycle.
   // The first word is the length, stored without the CRC.
   assign fifo_wr    = state == BS_RX_WORD && !rx_bad;
   assign fifo_wdata = !rx_have_len    ? enet_data_in - 16'd4 :
                       rx_rem == 16'd1 ? {8'h00, in_word.raw[7:0]} :
                                         enet_data_in;

   always_ff @(posedge clk_enet) begin
      if (reset) begin
         state       <= BS_IDLE;
         enet_ctrl   <= CTRL_IDLE;
         rx_bad      <= 1'b0;
         rx_have_len <= 1'b0;
      end else begin
         case (state)
            BS_IDLE: begin
               if (issue) begin
                  cur           <= cmd;
                  enet_data_out <= {8'h00, cmd.reg_idx};
                  enet_ctrl     <= CTRL_INDEX;
                  state         <= BS_INDEX;
               end
            end
            BS_INDEX: begin
               // Strobes high for one cycle between accesses.
               enet_ctrl <= CTRL_IDLE;
               state     <= BS_SPIN;
            end
            BS_SPIN: begin
               if (!cur.read) begin
                  enet_data_out <= cur.data;
                  enet_ctrl     <= CTRL_WRITE;
                  state         <= BS_WRITE;
               end else begin
                  enet_ctrl <= CTRL_READ;
                  state     <= (cur.reg_idx == REG_MRCMD) ? BS_RX_STAT : BS_READ;
               end
            end
            BS_WRITE: begin
               enet_ctrl <= CTRL_IDLE;
               state     <= BS_IDLE;
            end
            ////////////////////
            // Register reads and the prefetch.
            BS_READ: begin
               rd_data   <= in_word;
               enet_ctrl <= CTRL_IDLE;
               state     <= (cur.reg_idx == REG_MRCMDX) ? BS_PF_SPIN0 : BS_CAPTURE;
            end
            BS_PF_SPIN0: begin
               state <= BS_PF_SPIN1;
            end
            BS_PF_SPIN1: begin
               // The prefetch is only valid on the second read.
               enet_ctrl <= CTRL_READ;
               state     <= BS_PF_READ;
            end
            BS_PF_READ: begin
               rd_data   <= in_word;
               enet_ctrl <= CTRL_IDLE;
               state     <= BS_CAPTURE;
            end
            BS_CAPTURE: begin
               state <= BS_IDLE;
            end
            ////////////////////
            // Packet receive burst.
            BS_RX_STAT: begin
               rx_bad      <= (in_word.rx.status & RX_BAD_FLAGS) != 8'h00;
               rx_have_len <= 1'b0;
               enet_ctrl   <= CTRL_IDLE;
               state       <= BS_RX_CHECK;
            end
            BS_RX_CHECK: begin
               state <= BS_RX_REQ;
            end
            BS_RX_REQ: begin
               if (rx_have_len && rx_rem == 16'd0) begin
                  state <= BS_RX_CRC_SPIN;
               end else if (!rx_stall) begin
                  enet_ctrl <= CTRL_READ;
                  state     <= BS_RX_WORD;
               end
            end
            BS_RX_WORD: begin
               // Count down two bytes per word. An odd last byte ends the count at zero.
               rx_rem      <= !rx_have_len    ? fifo_wdata :
                              rx_rem == 16'd1 ? 16'd0 :
                                                rx_rem - 16'd2;
               rx_have_len <= 1'b1;
               enet_ctrl   <= CTRL_IDLE;
               state       <= BS_RX_REQ;
            end
            BS_RX_CRC_SPIN: begin
               enet_ctrl <= CTRL_READ;
               state     <= BS_RX_CRC;
            end
            BS_RX_CRC: begin
               enet_ctrl <= CTRL_IDLE;
               state     <= BS_RX_DONE;
            end
            BS_RX_DONE: begin
               state <= BS_IDLE;
            end
            default: begin
               enet_ctrl <= CTRL_IDLE;
               state     <= BS_IDLE;
            end
         endcase
      end
   end

   a_strobes: assert property (@(posedge clk_enet) disable iff (reset)
      !(!enet_ctrl.wr_n && !enet_ctrl.rd_n))
      else $error("Write and read strobes low together.");

   // Each strobe lasts one cycle so that every read advances the chip by one word.
   a_strobe_pulse: assert property (@(posedge clk_enet) disable iff (reset)
      (!enet_ctrl.wr_n || !enet_ctrl.rd_n) |=> (enet_ctrl.wr_n && enet_ctrl.rd_n))
      else $error("Bus strobe held low for more than one cycle.");

endmodule

// File: rtl/dm9000a_rx_fifo.sv
`timescale 1ns/1ps

module dm9000a_rx_fifo #(
   parameter int FIFO_DEPTH_LOG2 = 8
) (
   input  logic                       clk_enet,
   input  logic                       reset,
   input  logic                       wr,
   input  dm9000a_pkg::data_word_t    wdata,
   input  logic                       rd,
   output dm9000a_pkg::data_word_t    rdata,
   output logic                       full,
   output logic                       empty,
   output logic [FIFO_DEPTH_LOG2:0]   count
);
   import dm9000a_pkg::*;

   localparam int DEPTH = 1 << FIFO_DEPTH_LOG2;

   data_word_t                 mem [DEPTH];
   logic [FIFO_DEPTH_LOG2-1:0] wr_ptr;
   logic [FIFO_DEPTH_LOG2-1:0] rd_ptr;
   logic                       wr_ok;
   logic                       rd_ok;

   assign full  = count == (FIFO_DEPTH_LOG2 + 1)'(DEPTH);
   assign empty = count == '0;
   assign wr_ok = wr && !full;
   assign rd_ok = rd && !empty;

   always_ff @(posedge clk_enet) begin
      if (wr_ok) begin
         mem[wr_ptr] <= wdata;
      end
      // Read data shows up the cycle after rd.
      if (rd_ok) begin
         rdata <= mem[rd_ptr];
      end
   end

   always_ff @(posedge clk_enet) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         wr_ptr <= wr_ptr + FIFO_DEPTH_LOG2'(wr_ok);
         rd_ptr <= rd_ptr + FIFO_DEPTH_LOG2'(rd_ok);
         if (wr_ok && !rd_ok) begin
            count <= count + 1'b1;
         end else if (rd_ok && !wr_ok) begin
            count <= count - 1'b1;
         end
      end
   end

   a_no_overflow: assert property (@(posedge clk_enet) disable iff (reset) wr |-> !full)
      else $error("Receive FIFO written while full.");
   a_no_underflow: assert property (@(posedge clk_enet) disable iff (reset) rd |-> !empty)
      else $error("Receive FIFO read while empty.");

endmodule

// File: rtl/dm9000a_controller.sv
`timescale 1ns/1ps

module dm9000a_controller #(
   parameter logic [47:0] MAC_ADDRESS     = 48'h010203040506,
   parameter logic        PROMISCUOUS_EN  = 1'b1,
   parameter int          RESET_SPIN      = 1000,
   parameter int          PHY_SPIN        = 1000,
   parameter int          FIFO_DEPTH_LOG2 = 8
) (
   input  logic                       clk_enet,
   input  logic                       reset,
   input  logic                       enet_int,
   output dm9000a_pkg::enet_ctrl_t    enet_ctrl,
   output dm9000a_pkg::data_word_t    enet_data_out,
   input  dm9000a_pkg::data_word_t    enet_data_in,
   input  logic                       rx_rd,
   input  logic                       halt,
   output dm9000a_pkg::data_word_t    rx_data,
   output logic                       rx_empty,
   output logic [FIFO_DEPTH_LOG2:0]   rx_count,
   output logic                       link_status
);
   import dm9000a_pkg::*;

   logic       issue;
   bus_cmd_t   cmd;
   logic       busy;
   enet_word_u rd_data;
   logic       fifo_wr;
   data_word_t fifo_wdata;
   logic       fifo_full;

   dm9000a_cmd_ctrl #(
      .MAC_ADDRESS   (MAC_ADDRESS),
      .PROMISCUOUS_EN(PROMISCUOUS_EN),
      .RESET_SPIN    (RESET_SPIN),
      .PHY_SPIN      (PHY_SPIN)
   ) u_cmd_ctrl (
      .clk_enet   (clk_enet),
      .reset      (reset),
      .enet_int   (enet_int),
      .busy       (busy),
      .rd_data    (rd_data),
      .issue      (issue),
      .cmd        (cmd),
      .link_status(link_status)
   );

   dm9000a_bus_seq u_bus_seq (
      .clk_enet     (clk_enet),
      .reset        (reset),
      .issue        (issue),
      .cmd          (cmd),
      .enet_data_in (enet_data_in),
      .fifo_full    (fifo_full),
      .halt         (halt),
      .busy         (busy),
      .rd_data      (rd_data),
      .enet_ctrl    (enet_ctrl),
      .enet_data_out(enet_data_out),
      .fifo_wr      (fifo_wr),
      .fifo_wdata   (fifo_wdata)
   );

   dm9000a_rx_fifo #(
      .FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2)
   ) u_rx_fifo (
      .clk_enet(clk_enet),
      .reset   (reset),
      .wr      (fifo_wr),
      .wdata   (fifo_wdata),
      .rd      (rx_rd),
      .rdata   (rx_data),
      .full    (fifo_full),
      .empty   (rx_empty),
      .count   (rx_count)
   );

endmodule

// File: test/dm9000a_model.sv
`timescale 1ns/1ps

module dm9000a_model (
   input  logic                    clk_enet,
   input  dm9000a_pkg::enet_ctrl_t enet_ctrl,
   input  dm9000a_pkg::data_word_t enet_data_out,
   output dm9000a_pkg::data_word_t enet_data_in,
   output logic                    enet_int
);
   import dm9000a_pkg::*;

   localparam int LOG_SIZE = 64;

   logic [7:0] regs [256];
   enet_reg_t  index;
   logic       rd_n_q;
   logic       ready;
   data_word_t head_word;
   data_word_t sram [$];
   int         pkt_words [$];
   int         pos;
   int         pkt_count;
   bus_cmd_t   wr_log [LOG_SIZE];
   int         wr_count;

   initial begin
      for (int i = 0; i < 256; i++) begin
         regs[i] = 8'h00;
      end
      index     = 8'h00;
      rd_n_q    = 1'b1;
      ready     = 1'b0;
      head_word = 16'h0000;
      pos       = 0;
      pkt_count = 0;
      wr_count  = 0;
   end

   assign enet_int = (regs[REG_ISR] & regs[REG_IMR] & ISR_ALL) != 8'h00;

   // Read data follows the index register.
   always @* begin
      if (index == REG_MRCMD) begin
         enet_data_in = head_word;
      end else if (index == REG_MRCMDX) begin
         enet_data_in = {8'h00, ready ? 8'h01 : 8'h00};
      end else begin
         enet_data_in = {8'h00, regs[index]};
      end
   end

   task automatic update_head();
      ready     = pkt_words.size() > 0;
      head_word = (sram.size() > 0) ? sram[0] : 16'h0000;
      pkt_count = pkt_words.size();
   endtask

   // Status bits in ISR and NSR clear when written with one.
   task automatic write_reg(enet_reg_t idx, logic [7:0] value);
      if (wr_count < LOG_SIZE) begin
         wr_log[wr_count] = '{read: 1'b0, reg_idx: idx, data: {8'h00, value}};
      end
      wr_count = wr_count + 1;
      if (idx == REG_ISR || idx == REG_NSR) begin
         regs[idx] = regs[idx] & ~value;
      end else begin
         regs[idx] = value;
      end
   endtask

   task automatic push_word(data_word_t w);
      sram.push_back(w);
      update_head();
   endtask

   task automatic close_packet(int nwords);
      pkt_words.push_back(nwords);
      regs[REG_ISR] = regs[REG_ISR] | ISR_PR;
      update_head();
   endtask

   task automatic link_event(logic [7:0] nsr);
      regs[REG_NSR] = nsr;
      regs[REG_ISR] = regs[REG_ISR] | ISR_LNKCHG;
   endtask

   ////////////////////
   // Bus cycles are sampled mid-cycle, reads advance at the end of the strobe.
   always @(negedge clk_enet) begin
      if (enet_ctrl.wr_n == 1'b0) begin
         if (enet_ctrl.cmd == CMD_INDEX) begin
            index = enet_data_out[7:0];
         end else begin
            write_reg(index, enet_data_out[7:0]);
         end
      end
      if (!rd_n_q && enet_ctrl.rd_n && index == REG_MRCMD && sram.size() > 0) begin
         void'(sram.pop_front());
         pos = pos + 1;
         if (pkt_words.size() > 0 && pos == pkt_words[0]) begin
            void'(pkt_words.pop_front());
            pos = 0;
         end
         update_head();
      end
      rd_n_q = enet_ctrl.rd_n;
   end

endmodule

// File: test/tb_dm9000a_controller.sv
`timescale 1ns/1ps

module tb_dm9000a_controller;
   import dm9000a_pkg::*;

   localparam logic [47:0] MAC        = 48'h0123456789AB;
   localparam int          FIFO_LOG2  = 3;
   localparam int          WAIT_LIMIT = 2000;

   logic                 clk_enet;
   logic                 reset;
   logic                 enet_int;
   logic                 rx_rd;
   logic                 halt;
   logic                 rx_empty;
   logic                 link_status;
   enet_ctrl_t           enet_ctrl;
   data_word_t           enet_data_out;
   data_word_t           enet_data_in;
   data_word_t           rx_data;
   logic [FIFO_LOG2:0]   rx_count;
   logic [31:0]          lfsr;
   data_word_t           expected [$];
   int                   fd;
   int                   wr_seen;
   int                   stall_cycles;

   dm9000a_controller #(
      .MAC_ADDRESS    (MAC),
      .PROMISCUOUS_EN (1'b1),
      .RESET_SPIN     (20),
      .PHY_SPIN       (20),
      .FIFO_DEPTH_LOG2(FIFO_LOG2)
   ) uut (
      .clk_enet     (clk_enet),
      .reset        (reset),
      .enet_int     (enet_int),
      .enet_ctrl    (enet_ctrl),
      .enet_data_out(enet_data_out),
      .enet_data_in (enet_data_in),
      .rx_rd        (rx_rd),
      .halt         (halt),
      .rx_data      (rx_data),
      .rx_empty     (rx_empty),
      .rx_count     (rx_count),
      .link_status  (link_status)
   );

   dm9000a_model chip (
      .clk_enet     (clk_enet),
      .enet_ctrl    (enet_ctrl),
      .enet_data_out(enet_data_out),
      .enet_data_in (enet_data_in),
      .enet_int     (enet_int)
   );

   initial begin
      clk_enet = 1'b0;
      forever #5 clk_enet = ~clk_enet;
   end

   ////////////////////
   // Result reporting.
   task automatic stop_on_error(string msg);
      $display("%s", msg);
      $display("Simulation failed");
      $fatal(1);
   endtask

   task automatic check_word(data_word_t got, data_word_t exp, string what);
      if (got !== exp) begin
         stop_on_error($sformatf("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp));
      end
   endtask

   task automatic check_write(bus_cmd_t got, bus_cmd_t exp);
      if (got !== exp) begin
         stop_on_error($sformatf("FAILED at %0t: write reg %h data %h, expected reg %h data %h",
                                 $time, got.reg_idx, got.data, exp.reg_idx, exp.data));
      end
   endtask

   task automatic check_link(logic got, logic exp, string what);
      if (got !== exp) begin
         stop_on_error($sformatf("FAILED at %0t: %s is %b, expected %b",
                                 $time, what, got, exp));
      end
   endtask

   // Galois LFSR stepped once for each bit taken.
   function automatic logic [31:0] lfsr_step(logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'hA3000000) : (s >> 1);
   endfunction

   initial begin
      #5ms;
      stop_on_error("The simulation ran past its overall time limit.");
   end

   ////////////////////
   // Record handlers.
   task automatic expect_write(enet_reg_t idx, logic [7:0] value);
      bus_cmd_t exp;
      int       t;
      exp = '{read: 1'b0, reg_idx: idx, data: {8'h00, value}};
      t   = 0;
      while (chip.wr_count <= wr_seen) begin
         @(negedge clk_enet);
         t++;
         if (t > WAIT_LIMIT) begin
            stop_on_error("Timed out waiting for a register write from the controller.");
         end
      end
      check_write(chip.wr_log[wr_seen], exp);
      wr_seen++;
   endtask

   task automatic run_link(logic [7:0] nsr);
      int t;
      @(negedge clk_enet);
      #1 chip.link_event(nsr);
      t = 0;
      while ((chip.regs[REG_ISR] & ISR_LNKCHG) != 8'h00) begin
         @(negedge clk_enet);
         t++;
         if (t > WAIT_LIMIT) begin
            stop_on_error("Timed out waiting for the link change interrupt to be cleared.");
         end
      end
      t = 0;
      // Handler is done once the interrupt mask is back.
      while (chip.regs[REG_IMR] != IMR_RUN_FLAGS) begin
         @(negedge clk_enet);
         t++;
         if (t > WAIT_LIMIT) begin
            stop_on_error("Timed out waiting for the interrupt mask to be restored.");
         end
      end
      check_link(link_status, nsr[6], "link_status");
   endtask

   task automatic drain_fifo();
      int t;
      while (expected.size() > 0) begin
         t = 0;
         while (rx_empty) begin
            @(negedge clk_enet);
            t++;
            if (t > WAIT_LIMIT) begin
               stop_on_error("Timed out waiting for a word in the receive FIFO.");
            end
         end
         rx_rd = 1'b1;
         @(negedge clk_enet);
         rx_rd = 1'b0;
         check_word(rx_data, expected.pop_front(), "FIFO entry");
      end
   endtask

   task automatic run_packet(logic [7:0] status, int len);
      data_word_t words [$];
      data_word_t w;
      int         nwords;
      int         code;
      int         t;
      int         target;
      logic       bad;
      nwords = (len - 4 + 1) / 2;
      bad    = (status & RX_BAD_FLAGS) != 8'h00;
      for (int i = 0; i < nwords; i++) begin
         code = $fscanf(fd, "%h", w);
         if (code != 1) begin
            stop_on_error("A packet record in the test data is short of data words.");
         end
         words.push_back(w);
      end
      if (!bad) begin
         expected.push_back(data_word_t'(len - 4));
         for (int i = 0; i < nwords; i++) begin
            // Odd final byte arrives zero-extended.
            if ((len - 4) % 2 == 1 && i == nwords - 1) begin
               expected.push_back({8'h00, words[i][7:0]});
            end else begin
               expected.push_back(words[i]);
            end
         end
      end
      @(negedge clk_enet);
      #1;
      chip.push_word({status, 8'h01});
      chip.push_word(data_word_t'(len));
      foreach (words[i]) begin
         chip.push_word(words[i]);
      end
      chip.push_word(16'hC3C3);
      chip.close_packet(nwords + 3);
      // Toggle halt from the LFSR while the frame is being received.
      for (int i = 0; i < stall_cycles; i++) begin
         @(negedge clk_enet);
         halt = lfsr[0];
         lfsr = lfsr_step(lfsr);
      end
      @(negedge clk_enet);
      halt         = 1'b0;
      stall_cycles = 0;
      if (bad) begin
         t = 0;
         while (chip.pkt_count != 0) begin
            @(negedge clk_enet);
            t++;
            if (t > WAIT_LIMIT) begin
               stop_on_error("Timed out waiting for a bad packet to be drained.");
            end
         end
         check_word(data_word_t'(rx_count), 16'h0000, "FIFO count after bad packet");
         check_link(rx_empty, 1'b1, "rx_empty after bad packet");
      end else begin
         // Hold off reading until the FIFO is full or holds the whole frame.
         target = (expected.size() < (1 << FIFO_LOG2)) ? expected.size() : (1 << FIFO_LOG2);
         t      = 0;
         while (int'(rx_count) < target) begin
            @(negedge clk_enet);
            t++;
            if (t > WAIT_LIMIT) begin
               stop_on_error("Timed out waiting for the receive FIFO to fill.");
            end
         end
         drain_fifo();
      end
   endtask

   ////////////////////
   // Main sequence.
   initial begin
      logic [7:0] tag;
      logic [7:0] a;
      logic [7:0] b;
      int         n;
      int         t;
      int         code;
      string      line;
      reset        = 1'b1;
      rx_rd        = 1'b0;
      halt         = 1'b0;
      lfsr         = 32'd94037;
      wr_seen      = 0;
      stall_cycles = 0;
      repeat (4) @(negedge clk_enet);
      reset = 1'b0;
      fd = $fopen("test/dm9000a_testdata.txt", "r");
      if (fd == 0) begin
         stop_on_error("Could not open test/dm9000a_testdata.txt.");
      end
      while (!$feof(fd)) begin
         code = $fscanf(fd, " %c", tag);
         if (code != 1) begin
            break;
         end
         case (tag)
            "#": void'($fgets(line, fd));
            "W": begin
               code = $fscanf(fd, "%h %h", a, b);
               expect_write(a, b);
            end
            "L": begin
               code = $fscanf(fd, "%h", a);
               run_link(a);
            end
            "H": begin
               code = $fscanf(fd, "%d", n);
               stall_cycles = n;
            end
            "P": begin
               code = $fscanf(fd, "%h %d", a, n);
               run_packet(a, n);
            end
            default: stop_on_error("Unknown record tag in the test data.");
         endcase
      end
      $fclose(fd);
      // The CRC of the last frame is read after its data words leave the FIFO.
      t = 0;
      while (chip.pkt_count != 0) begin
         @(negedge clk_enet);
         t++;
         if (t > WAIT_LIMIT) begin
            stop_on_error("Timed out waiting for the controller to finish the last packet.");
         end
      end
      check_word(data_word_t'(rx_count), 16'h0000, "FIFO count at end");
      check_link(rx_empty, 1'b1, "rx_empty at end");
      $display("Simulation completed successfully");
      $finish;
   end

endmodule

// File: test/dm9000a_testdata.txt
# W reg data (hex) | L nsr (hex) | H stall cycles (dec)
# P status (hex) length in bytes (dec) then ceil((length-4)/2) data words (hex)
W 00 01
W 1F 00
W 01 2C
W FE 3F
W 10 AB
W 11 89
W 12 67
W 13 45
W 14 23
W 15 01
W 05 03
W FF A1
L 40
L 00
L 40
P 00 12 1111 2222 3333 4444
P 00 9 A1B2 C3D4 77E5
P 02 20 DEAD BEEF 0BAD F00D CAFE 1234 5678 9ABC
P 00 7 0102 FF03
H 40
P 00 30 1001 1002 1003 1004 1005 1006 1007 1008 1009 100A 100B 100C 100D
P 40 10 2001 2002 2003
H 25
P 00 21 3001 3002 3003 3004 3005 3006 3007 3008 5509

// File: dm9000a_rx.f
rtl/dm9000a_pkg.sv
rtl/dm9000a_init_rom.sv
rtl/dm9000a_cmd_ctrl.sv
rtl/dm9000a_bus_seq.sv
rtl/dm9000a_rx_fifo.sv
rtl/dm9000a_controller.sv
test/dm9000a_model.sv
test/tb_dm9000a_controller.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --top-module tb_dm9000a_controller \
   -f dm9000a_rx.f -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log
if grep -q "Simulation failed" sim.log; then
   exit 1
fi
if ! grep -q "Simulation completed successfully" sim.log; then
   echo "No result message found in sim.log"
   exit 1
fi
exit 0
